// ==== verilog/uart_dbg_defs.svh ====
//////////////////////////////////////////////////
// UART debug server constants
// Serial timing, memory geometry and the
// protocol byte codes
//////////////////////////////////////////////////

`ifndef UART_DBG_DEFS_SVH
`define UART_DBG_DEFS_SVH

// Serial line timing
`define UART_CLKS_PER_BIT 8

// Memory geometry and burst counter
`define MEM_DEPTH         256
`define MEM_ADDR_W        8
`define LEN_W             16

// Protocol codes
`define CMD_READ          8'h11
`define CMD_WRITE         8'h12
`define BYTE_ACK          8'h06
`define BYTE_EOT          8'h04

`endif

// ==== verilog/uart_dbg_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the UART debug server
// Vector typedefs and FSM state enums
//////////////////////////////////////////////////

`default_nettype none

`include "uart_dbg_defs.svh"

package uart_dbg_pkg;

  typedef logic [7:0]                              byte_t;
  typedef logic [`MEM_ADDR_W-1:0]                  mem_addr_t;
  typedef logic [`LEN_W-1:0]                       burst_len_t;
  // Holds any count up to one full bit period
  typedef logic [$clog2(`UART_CLKS_PER_BIT+1)-1:0] bit_cnt_t;

  typedef enum logic [1:0] {
    RESP_ACK,
    RESP_EOT,
    RESP_DATA
  } resp_kind_e;

  typedef enum logic [2:0] {
    DEC_IDLE,
    DEC_ADDR,
    DEC_LEN,
    DEC_RESP,
    DEC_STREAM
  } dec_state_e;

  // Shared by receiver and transmitter
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

// ==== verilog/mem_if.sv ====
//////////////////////////////////////////////////
// Byte memory request bus
// Decoder side issues, execute side answers
//////////////////////////////////////////////////

`default_nettype none

interface mem_if import uart_dbg_pkg::*; ();

  logic      req;
  logic      we;
  mem_addr_t addr;
  byte_t     wdata;
  byte_t     rdata;

  modport dec (output req, output we, output addr, output wdata, input rdata);

  modport exe (input req, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== verilog/uart_rx.sv ====
//////////////////////////////////////////////////
// UART receiver, 8N1, LSB first
// Two-flop synchronizer and mid-bit sampling
//////////////////////////////////////////////////

`default_nettype none

`include "uart_dbg_defs.svh"

module uart_rx import uart_dbg_pkg::*; (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_byte_o
);

  localparam bit_cnt_t LAST_CNT = bit_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam bit_cnt_t HALF_CNT = bit_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);

  logic        rx_meta_q;
  logic        rx_sync_q;
  logic        rx_prev_q;
  uart_state_e state_q;
  bit_cnt_t    clk_cnt_q;
  logic [2:0]  bit_idx_q;
  logic        valid_q;
  byte_t       shift_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      state_q   <= UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      valid_q   <= 1'b0;
      case (state_q)
        UART_IDLE: begin
          // Falling edge marks a possible start bit
          if (rx_prev_q && !rx_sync_q) begin
            state_q   <= UART_START;
            clk_cnt_q <= '0;
          end
        end
        UART_START: begin
          if (clk_cnt_q == HALF_CNT) begin
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            // Glitch shorter than half a bit goes back to idle
            state_q   <= rx_sync_q ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + bit_cnt_t'(1);
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == LAST_CNT) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 3'd1;
            if (bit_idx_q == 3'd7) state_q <= UART_STOP;
          end else begin
            clk_cnt_q <= clk_cnt_q + bit_cnt_t'(1);
          end
        end
        default: begin
          if (clk_cnt_q == LAST_CNT) begin
            // Byte only counts with a valid stop bit
            valid_q <= rx_sync_q;
            state_q <= UART_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + bit_cnt_t'(1);
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == UART_DATA && clk_cnt_q == LAST_CNT) shift_q <= {rx_sync_q, shift_q[7:1]};
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = shift_q;

endmodule

`default_nettype wire

// ==== verilog/cmd_decode.sv ====
//////////////////////////////////////////////////
// Debug protocol decoder
// Parses ACK challenge and read/write bursts,
// issues memory and response requests
//////////////////////////////////////////////////

`default_nettype none

`include "uart_dbg_defs.svh"

module cmd_decode import uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       rx_valid_i,
  input  byte_t      rx_byte_i,
  mem_if.dec         mem,
  output logic       resp_send_o,
  output resp_kind_e resp_kind_o,
  input  logic       tx_busy_i
);

  localparam int LEN_BYTES = `LEN_W / 8;

  dec_state_e state_q;
  logic       is_write_q;
  logic       in_cmd_q;
  logic [2:0] field_cnt_q;
  mem_addr_t  addr_q;
  burst_len_t len_q;
  resp_kind_e pend_kind_q;
  logic       wr_pend_q;
  byte_t      wdata_q;
  logic       rd_issue;
  logic       last_beat;

  // One read beat whenever the transmitter is free
  assign rd_issue  = (state_q == DEC_STREAM) && !is_write_q && !tx_busy_i;
  assign last_beat = (len_q == burst_len_t'(1));

  always_comb begin
    resp_send_o = 1'b0;
    resp_kind_o = pend_kind_q;
    if (state_q == DEC_RESP && !tx_busy_i) begin
      resp_send_o = 1'b1;
    end else if (rd_issue) begin
      resp_send_o = 1'b1;
      resp_kind_o = RESP_DATA;
    end
  end

  assign mem.req   = wr_pend_q | rd_issue;
  assign mem.we    = wr_pend_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  //////////////////////////////////////////////////
  // Protocol FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= DEC_IDLE;
      is_write_q  <= 1'b0;
      in_cmd_q    <= 1'b0;
      field_cnt_q <= '0;
      addr_q      <= '0;
      len_q       <= '0;
      pend_kind_q <= RESP_ACK;
      wr_pend_q   <= 1'b0;
    end else begin
      wr_pend_q <= 1'b0;
      case (state_q)
        DEC_IDLE: begin
          // Anything other than a known code is dropped here
          if (rx_valid_i && rx_byte_i == `BYTE_ACK) begin
            pend_kind_q <= RESP_ACK;
            state_q     <= DEC_RESP;
          end else if (rx_valid_i && (rx_byte_i == `CMD_READ || rx_byte_i == `CMD_WRITE)) begin
            is_write_q  <= (rx_byte_i == `CMD_WRITE);
            in_cmd_q    <= 1'b1;
            field_cnt_q <= '0;
            state_q     <= DEC_ADDR;
          end
        end
        DEC_ADDR: begin
          if (rx_valid_i) begin
            // Little endian, only the first byte reaches the memory
            if (field_cnt_q == '0) addr_q <= rx_byte_i;
            field_cnt_q <= field_cnt_q + 3'd1;
            if (field_cnt_q == 3'd7) state_q <= DEC_LEN;
          end
        end
        DEC_LEN: begin
          if (rx_valid_i) begin
            if (field_cnt_q < LEN_BYTES) len_q[8*field_cnt_q +: 8] <= rx_byte_i;
            field_cnt_q <= field_cnt_q + 3'd1;
            if (field_cnt_q == 3'd7) begin
              pend_kind_q <= RESP_ACK;
              state_q     <= DEC_RESP;
            end
          end
        end
        DEC_RESP: begin
          if (!tx_busy_i) begin
            if (in_cmd_q && pend_kind_q == RESP_ACK) begin
              // Zero length goes straight on to EOT
              if (len_q == '0) pend_kind_q <= RESP_EOT;
              else state_q <= DEC_STREAM;
            end else begin
              in_cmd_q <= 1'b0;
              state_q  <= DEC_IDLE;
            end
          end
        end
        default: begin
          if (rd_issue || wr_pend_q) begin
            addr_q <= addr_q + mem_addr_t'(1);
            len_q  <= len_q - burst_len_t'(1);
            if (last_beat) begin
              pend_kind_q <= RESP_EOT;
              state_q     <= DEC_RESP;
            end
          end
          if (is_write_q && rx_valid_i) wr_pend_q <= 1'b1;
        end
      endcase
    end
  end

  // Write data held for the request cycle
  always_ff @(posedge clk) begin
    if (rx_valid_i) wdata_q <= rx_byte_i;
  end

endmodule

`default_nettype wire

// ==== verilog/mem_exec.sv ====
//////////////////////////////////////////////////
// Debug target memory
// Byte array with registered read data
//////////////////////////////////////////////////

`default_nettype none

`include "uart_dbg_defs.svh"

module mem_exec import uart_dbg_pkg::*; (
  input  logic clk,
  input  logic rst_n_i,
  mem_if.exe   mem
);

  byte_t mem_q [`MEM_DEPTH];
  byte_t rdata_q;

  // Write lands on the edge of the request
  always_ff @(posedge clk) begin
    if (mem.req && mem.we) mem_q[mem.addr] <= mem.wdata;
  end

  // Read data one cycle after the request
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (mem.req && !mem.we) begin
      rdata_q <= mem_q[mem.addr];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/resp_tx.sv ====
//////////////////////////////////////////////////
// Response transmitter
// Picks ACK, EOT or memory data and sends it
// as one 8N1 frame
//////////////////////////////////////////////////

`default_nettype none

`include "uart_dbg_defs.svh"

module resp_tx import uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       resp_send_i,
  input  resp_kind_e resp_kind_i,
  input  byte_t      rdata_i,
  output logic       tx_busy_o,
  output logic       tx_o
);

  localparam bit_cnt_t LAST_CNT = bit_cnt_t'(`UART_CLKS_PER_BIT - 1);

  uart_state_e state_q;
  bit_cnt_t    clk_cnt_q;
  logic [2:0]  bit_idx_q;
  logic        load_q;
  logic        busy_q;
  logic        tx_q;
  resp_kind_e  kind_q;
  byte_t       shift_q;
  byte_t       tx_byte;
  logic        bit_end;

  // Memory data is valid one cycle after the send strobe
  always_comb begin
    case (kind_q)
      RESP_ACK: tx_byte = `BYTE_ACK;
      RESP_EOT: tx_byte = `BYTE_EOT;
      default:  tx_byte = rdata_i;
    endcase
  end

  assign bit_end = (clk_cnt_q == LAST_CNT);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      load_q    <= 1'b0;
      busy_q    <= 1'b0;
      tx_q      <= 1'b1;
    end else begin
      load_q <= resp_send_i;
      if (resp_send_i) busy_q <= 1'b1;
      if (state_q != UART_IDLE) clk_cnt_q <= bit_end ? '0 : clk_cnt_q + bit_cnt_t'(1);
      case (state_q)
        UART_IDLE: begin
          if (load_q) begin
            state_q   <= UART_START;
            clk_cnt_q <= '0;
            tx_q      <= 1'b0;
          end
        end
        UART_START: begin
          if (bit_end) begin
            bit_idx_q <= '0;
            tx_q      <= shift_q[0];
            state_q   <= UART_DATA;
          end
        end
        UART_DATA: begin
          if (bit_end) begin
            bit_idx_q <= bit_idx_q + 3'd1;
            tx_q      <= (bit_idx_q == 3'd7) ? 1'b1 : shift_q[0];
            if (bit_idx_q == 3'd7) state_q <= UART_STOP;
          end
        end
        default: begin
          // Busy drops only once the stop bit is complete
          if (bit_end) begin
            busy_q  <= 1'b0;
            state_q <= UART_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (resp_send_i) kind_q <= resp_kind_i;
    if (load_q) begin
      shift_q <= tx_byte;
    end else if (bit_end && (state_q == UART_START || state_q == UART_DATA)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  assign tx_busy_o = busy_q;
  assign tx_o      = tx_q;

endmodule

`default_nettype wire

// ==== verilog/uart_dbg_top.sv ====
//////////////////////////////////////////////////
// UART debug server top level
// Receiver, decoder, memory and transmitter
//////////////////////////////////////////////////

`default_nettype none

module uart_dbg_top import uart_dbg_pkg::*; (
  input  logic clk,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  logic       rx_valid;
  byte_t      rx_byte;
  logic       resp_send;
  resp_kind_e resp_kind;
  logic       tx_busy;

  mem_if mem_bus ();

  uart_rx uart_rx_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  cmd_decode cmd_decode_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_valid_i  (rx_valid),
    .rx_byte_i   (rx_byte),
    .mem         (mem_bus.dec),
    .resp_send_o (resp_send),
    .resp_kind_o (resp_kind),
    .tx_busy_i   (tx_busy)
  );

  mem_exec mem_exec_inst (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .mem     (mem_bus.exe)
  );

  // Read data comes straight off the memory bus
  resp_tx resp_tx_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .resp_send_i (resp_send),
    .resp_kind_i (resp_kind),
    .rdata_i     (mem_bus.rdata),
    .tx_busy_o   (tx_busy),
    .tx_o        (uart_tx_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset generator
// 4 ns clock, reset low for 4 cycles
//////////////////////////////////////////////////

`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Release just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_uart_dbg.sv ====
//////////////////////////////////////////////////
// Testbench for the UART debug server
// Host UART tasks, reference memory model,
// response compare process and reporting
//////////////////////////////////////////////////

`default_nettype none

`include "uart_dbg_defs.svh"

module tb_uart_dbg import uart_dbg_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CPB            = `UART_CLKS_PER_BIT;
  localparam int MISS_CYCLES    = 30 * CPB;
  localparam int SETTLE_CYCLES  = 20 * CPB;
  localparam int TIMEOUT_CYCLES = 60000;
  localparam int SEED           = 29094;

  logic clk;
  logic rst_n;
  logic uart_rx;
  logic uart_tx;

  byte_t model_mem [`MEM_DEPTH];
  byte_t wr_buf [`MEM_DEPTH];
  byte_t exp_q [$];
  int    err_cnt       = 0;
  int    test_cnt      = 0;
  int    test_fail_cnt = 0;
  int    test_err_base = 0;
  int    cycle_cnt     = 0;
  logic  frame_busy    = 1'b0;

  tb_clk_gen tb_clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  uart_dbg_top uart_dbg_top_inst (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .uart_rx_i (uart_rx),
    .uart_tx_o (uart_tx)
  );

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////

  // 8N1 frame, LSB first, bits change 1 ns after the edge
  task automatic send_byte(input byte_t data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1 uart_rx = frame[i];
      repeat (CPB - 1) @(posedge clk);
    end
  endtask

  // Command code, then little endian address and length
  task automatic send_cmd(input byte_t cmd, input logic [63:0] addr, input logic [63:0] len);
    send_byte(cmd);
    for (int i = 0; i < 8; i++) send_byte(addr[8*i +: 8]);
    for (int i = 0; i < 8; i++) send_byte(len[8*i +: 8]);
  endtask

  // Expected response bytes of one command, model memory updated for writes
  function automatic void model_cmd(input byte_t cmd, input logic [63:0] addr,
                                    input logic [63:0] len);
    int a;
    int n;
    a = int'(addr % `MEM_DEPTH);
    n = int'(len % (64'd1 << `LEN_W));
    exp_q.push_back(`BYTE_ACK);
    if (cmd != `BYTE_ACK) begin
      for (int i = 0; i < n; i++) begin
        if (cmd == `CMD_READ) exp_q.push_back(model_mem[a]);
        else model_mem[a] = wr_buf[i];
        a = (a + 1) % `MEM_DEPTH;
      end
      exp_q.push_back(`BYTE_EOT);
    end
  endfunction

  // Wait until only the given number of expected bytes are left
  task automatic wait_responses(input int remaining);
    int idle_cnt;
    idle_cnt = 0;
    while (exp_q.size() > remaining) begin
      @(posedge clk);
      if (frame_busy) idle_cnt = 0;
      else idle_cnt++;
      if (idle_cnt >= MISS_CYCLES) begin
        $display("ERROR: response missing, no start bit on uart_tx_o in 30 bit times (%0d left)",
                 exp_q.size());
        err_cnt++;
        exp_q.delete();
      end
    end
  endtask

  task automatic write_burst(input logic [63:0] addr, input int count);
    for (int i = 0; i < count; i++) wr_buf[i] = byte_t'($urandom());
    model_cmd(`CMD_WRITE, addr, 64'(count));
    send_cmd(`CMD_WRITE, addr, 64'(count));
    // Data only goes out once ACK is back
    wait_responses(1);
    for (int i = 0; i < count; i++) send_byte(wr_buf[i]);
    wait_responses(0);
  endtask

  task automatic read_burst(input logic [63:0] addr, input logic [63:0] len);
    model_cmd(`CMD_READ, addr, len);
    send_cmd(`CMD_READ, addr, len);
    wait_responses(0);
  endtask

  // Idle time catches any extra byte before the verdict
  task automatic end_test(input string name);
    repeat (SETTLE_CYCLES) @(posedge clk);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("Test %0d %s: passed", test_cnt, name);
    end else begin
      test_fail_cnt++;
      $display("Test %0d %s: FAILED with %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // Response capture and compare
  //////////////////////////////////////////////////

  initial begin : rx_compare
    byte_t got;
    byte_t want;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      frame_busy = 1'b1;
      // Sample on falling clock, away from the DUT edge
      repeat (CPB / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        $display("ERROR: start bit on uart_tx_o was not low at mid-bit");
        err_cnt++;
      end else begin
        for (int i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          got[i] = uart_tx;
        end
        repeat (CPB) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          $display("ERROR: stop bit on uart_tx_o was not high");
          err_cnt++;
        end
        if (exp_q.size() == 0) begin
          $display("ERROR: unexpected response byte 0x%02h on uart_tx_o", got);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          if (got !== want) begin
            $display("MISMATCH uart_tx_o: expected 0x%02h, got 0x%02h", want, got);
            err_cnt++;
          end
        end
      end
      frame_busy = 1'b0;
    end
  end

  // Run limit, about 500 frames plus margin
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout after %0d cycles, the tests did not complete", cycle_cnt);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main_seq
    uart_rx = 1'b1;
    void'($urandom(SEED));
    wait (rst_n === 1'b1);
    repeat (4 * CPB) @(posedge clk);

    model_cmd(`BYTE_ACK, 64'd0, 64'd0);
    send_byte(`BYTE_ACK);
    wait_responses(0);
    end_test("ack challenge");

    write_burst(64'h20, 16);
    read_burst(64'h20, 64'd16);
    end_test("write and read burst");

    write_burst(64'hFC, 8);
    read_burst(64'hFC, 64'd8);
    end_test("address wrap");

    read_burst(64'h40, 64'd0);
    end_test("zero length read");

    // Stray byte must stay silent
    send_byte(8'h55);
    repeat (MISS_CYCLES) @(posedge clk);
    model_cmd(`BYTE_ACK, 64'd0, 64'd0);
    send_byte(`BYTE_ACK);
    wait_responses(0);
    end_test("stray byte");

    read_burst(64'hA5C3_0000_1234_5624, 64'h0000_7700_00EE_0004);
    end_test("upper address and length bytes");

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+verilog
verilog/uart_dbg_pkg.sv
verilog/mem_if.sv
verilog/uart_rx.sv
verilog/cmd_decode.sv
verilog/mem_exec.sv
verilog/resp_tx.sv
verilog/uart_dbg_top.sv
tb/tb_clk_gen.sv
tb/tb_uart_dbg.sv

// ==== Bender.yml ====
package:
  name: uart_dbg

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_dbg_pkg.sv
      - verilog/mem_if.sv
      - verilog/uart_rx.sv
      - verilog/cmd_decode.sv
      - verilog/mem_exec.sv
      - verilog/resp_tx.sv
      - verilog/uart_dbg_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_uart_dbg.sv
